// File: tapes_consts.svh
`ifndef TAPES_CONSTS_SVH
`define TAPES_CONSTS_SVH

// word and lane sizes
`define TAPE_WORD_W      64
`define LANE_W           32

// ram map, tape words first, aux words right after
`define TAPE_DEPTH       256
`define RAM_ADDR_W       9
`define AUX_BASE         256

// aux accumulation shape
`define NUM_ROUNDS       8
`define NUM_SBOX         4       // indices per round
`define READS_PER_INDEX  8
`define READ_STRIDE      32      // word distance between strided reads

// xorshift32 seed
`define SEED_W           32

`endif

// File: tapes_pkg.sv
`include "tapes_consts.svh"

package tapes_pkg;

    // one request on the shared ram port
    typedef struct packed {
        logic                     we;     // 1 = write, 0 = read
        logic [`RAM_ADDR_W-1:0]   addr;
        logic [`TAPE_WORD_W-1:0]  wdata;  // ignored on reads
    } mem_req_t;

    // one beat on the aux output stream
    typedef struct packed {
        logic [`TAPE_WORD_W-1:0]  data;   // aux word of one round
        logic                     last;   // final round
    } aux_beat_t;

endpackage

// File: shared_ram.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module shared_ram (
    input  logic                    clk,
    input  tapes_pkg::mem_req_t     req_i,
    input  logic                    req_valid_i,
    output logic [`TAPE_WORD_W-1:0] rdata_o
);

    // tape words at 0..255, aux words at AUX_BASE..AUX_BASE+7
    localparam int RAM_WORDS = `TAPE_DEPTH + `NUM_ROUNDS;

    logic [`TAPE_WORD_W-1:0] mem [0:RAM_WORDS-1];

    always_ff @(posedge clk)
    begin
        if (req_valid_i)
        begin
            if (req_i.we)
            begin
                mem[req_i.addr] <= req_i.wdata;
            end
            else
            begin
                rdata_o <= mem[req_i.addr];     // one cycle read latency
            end
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  tapes_pkg::mem_req_t fill_req_i,
    input  tapes_pkg::mem_req_t acc_req_i,
    input  tapes_pkg::mem_req_t strm_req_i,
    input  logic                fill_valid_i,
    input  logic                acc_valid_i,
    input  logic                strm_valid_i,
    output logic                fill_grant_o,
    output logic                acc_grant_o,
    output logic                strm_grant_o,
    output tapes_pkg::mem_req_t ram_req_o,
    output logic                ram_valid_o
);

    // fixed priority, filler > accumulator > streamer
    always_comb
    begin
        fill_grant_o = fill_valid_i;
        acc_grant_o  = acc_valid_i && !fill_valid_i;
        strm_grant_o = strm_valid_i && !fill_valid_i && !acc_valid_i;
    end

    assign ram_valid_o = fill_valid_i || acc_valid_i || strm_valid_i;

    // request mux follows the grant
    always_comb
    begin
        if (fill_grant_o)
        begin
            ram_req_o = fill_req_i;
        end
        else if (acc_grant_o)
        begin
            ram_req_o = acc_req_i;
        end
        else
        begin
            ram_req_o = strm_req_i;     // don't care when nobody asks
        end
    end

endmodule

// File: tape_filler.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module tape_filler (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_valid_i,
    input  logic [`SEED_W-1:0]  seed_i,
    input  logic                grant_i,
    input  logic                stream_done_i,
    output logic                start_ready_o,
    output tapes_pkg::mem_req_t req_o,
    output logic                req_valid_o,
    output logic                fill_done_o
);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_RUN,
        FILL_WAIT       // engine busy downstream
    } fill_state_t;

    fill_state_t            state_q;
    logic [`RAM_ADDR_W-1:0] waddr_q;
    logic [`SEED_W-1:0]     xs_q;
    logic [`LANE_W-1:0]     lo_lane;
    logic [`LANE_W-1:0]     hi_lane;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [`SEED_W-1:0] xs_step(input logic [`SEED_W-1:0] x);
        logic [`SEED_W-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign lo_lane = xs_step(xs_q);     // first step
    assign hi_lane = xs_step(lo_lane);  // second step

    assign start_ready_o = (state_q == FILL_IDLE);
    assign req_valid_o   = (state_q == FILL_RUN);

    always_comb
    begin
        req_o.we    = 1'b1;
        req_o.addr  = waddr_q;
        req_o.wdata = {hi_lane, lo_lane};
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q     <= FILL_IDLE;
            waddr_q     <= '0;
            fill_done_o <= 1'b0;
        end
        else
        begin
            fill_done_o <= 1'b0;
            case (state_q)
                FILL_IDLE:
                begin
                    if (start_valid_i)
                    begin
                        state_q <= FILL_RUN;
                        waddr_q <= '0;
                    end
                end
                FILL_RUN:
                begin
                    if (grant_i)
                    begin
                        waddr_q <= waddr_q + 1'b1;
                        if (waddr_q == `RAM_ADDR_W'(`TAPE_DEPTH - 1))
                        begin
                            state_q     <= FILL_WAIT;
                            fill_done_o <= 1'b1;    // kicks the accumulator
                        end
                    end
                end
                FILL_WAIT:
                begin
                    if (stream_done_i)
                    begin
                        state_q <= FILL_IDLE;
                    end
                end
                default: state_q <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_valid_i && start_ready_o)
        begin
            xs_q <= seed_i;
        end
        else if (req_valid_o && grant_i)
        begin
            xs_q <= hi_lane;                // two steps per word
        end
    end

endmodule

// File: aux_accumulator.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module aux_accumulator (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  logic                    grant_i,
    input  logic [`TAPE_WORD_W-1:0] rdata_i,
    output tapes_pkg::mem_req_t     req_o,
    output logic                    req_valid_o,
    output logic                    done_o
);

    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_READ,
        ACC_DRAIN,      // last read of the round still in flight
        ACC_WRITE
    } acc_state_t;

    acc_state_t                             state_q;
    logic [$clog2(`NUM_ROUNDS)-1:0]         round_q;
    logic [$clog2(`NUM_SBOX)-1:0]           idx_q;
    logic [$clog2(`READS_PER_INDEX)-1:0]    step_q;
    logic                                   rd_pend_q;
    logic [`TAPE_WORD_W-1:0]                acc_q;
    logic [`RAM_ADDR_W-1:0]                 rd_addr;
    logic [`RAM_ADDR_W-1:0]                 wr_addr;

    // round*4 + idx + 32*step
    assign rd_addr = `RAM_ADDR_W'(round_q) * `RAM_ADDR_W'(`NUM_SBOX)
                   + `RAM_ADDR_W'(idx_q)
                   + `RAM_ADDR_W'(step_q) * `RAM_ADDR_W'(`READ_STRIDE);
    assign wr_addr = `RAM_ADDR_W'(`AUX_BASE) + `RAM_ADDR_W'(round_q);

    assign req_valid_o = (state_q == ACC_READ) || (state_q == ACC_WRITE);

    always_comb
    begin
        req_o.we    = (state_q == ACC_WRITE);
        req_o.addr  = (state_q == ACC_WRITE) ? wr_addr : rd_addr;
        req_o.wdata = acc_q;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q   <= ACC_IDLE;
            round_q   <= '0;
            idx_q     <= '0;
            step_q    <= '0;
            rd_pend_q <= 1'b0;
            done_o    <= 1'b0;
        end
        else
        begin
            done_o    <= 1'b0;
            rd_pend_q <= (state_q == ACC_READ) && grant_i;  // data back next cycle
            case (state_q)
                ACC_IDLE:
                begin
                    if (start_i)
                    begin
                        state_q <= ACC_READ;
                        round_q <= '0;
                        idx_q   <= '0;
                        step_q  <= '0;
                    end
                end
                ACC_READ:
                begin
                    if (grant_i)
                    begin
                        step_q <= step_q + 1'b1;
                        if (step_q == ($clog2(`READS_PER_INDEX))'(`READS_PER_INDEX - 1))
                        begin
                            idx_q <= idx_q + 1'b1;
                            if (idx_q == ($clog2(`NUM_SBOX))'(`NUM_SBOX - 1))
                            begin
                                state_q <= ACC_DRAIN;
                            end
                        end
                    end
                end
                ACC_DRAIN: state_q <= ACC_WRITE;
                ACC_WRITE:
                begin
                    if (grant_i)
                    begin
                        round_q <= round_q + 1'b1;
                        if (round_q == ($clog2(`NUM_ROUNDS))'(`NUM_ROUNDS - 1))
                        begin
                            state_q <= ACC_IDLE;
                            done_o  <= 1'b1;        // all aux words stored
                        end
                        else
                        begin
                            state_q <= ACC_READ;
                        end
                    end
                end
                default: state_q <= ACC_IDLE;
            endcase
        end
    end

    // both lanes xor'd independently, mode 0 style
    always_ff @(posedge clk)
    begin
        if (start_i || ((state_q == ACC_WRITE) && grant_i))
        begin
            acc_q <= '0;
        end
        else if (rd_pend_q)
        begin
            acc_q[`LANE_W-1:0] <= acc_q[`LANE_W-1:0] ^ rdata_i[`LANE_W-1:0];
            acc_q[`TAPE_WORD_W-1:`LANE_W] <= acc_q[`TAPE_WORD_W-1:`LANE_W]
                                           ^ rdata_i[`TAPE_WORD_W-1:`LANE_W];
        end
    end

endmodule

// File: aux_streamer.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module aux_streamer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  logic                    grant_i,
    input  logic [`TAPE_WORD_W-1:0] rdata_i,
    input  logic                    aux_ready_i,
    output tapes_pkg::mem_req_t     req_o,
    output logic                    req_valid_o,
    output logic                    aux_valid_o,
    output tapes_pkg::aux_beat_t    aux_o,
    output logic                    done_o
);

    typedef enum logic [1:0] {
        STR_IDLE,
        STR_READ,
        STR_CAPT,       // rdata lands this cycle
        STR_HOLD        // beat offered
    } str_state_t;

    str_state_t                     state_q;
    logic [$clog2(`NUM_ROUNDS)-1:0] round_q;
    logic                           last_round;

    assign last_round  = (round_q == ($clog2(`NUM_ROUNDS))'(`NUM_ROUNDS - 1));
    assign req_valid_o = (state_q == STR_READ);
    assign aux_valid_o = (state_q == STR_HOLD);
    assign done_o      = aux_valid_o && aux_ready_i && aux_o.last;

    always_comb
    begin
        req_o.we    = 1'b0;
        req_o.addr  = `RAM_ADDR_W'(`AUX_BASE) + `RAM_ADDR_W'(round_q);
        req_o.wdata = '0;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= STR_IDLE;
            round_q <= '0;
        end
        else
        begin
            case (state_q)
                STR_IDLE:
                begin
                    if (start_i)
                    begin
                        state_q <= STR_READ;
                        round_q <= '0;
                    end
                end
                STR_READ: if (grant_i) state_q <= STR_CAPT;
                STR_CAPT: state_q <= STR_HOLD;
                STR_HOLD:
                begin
                    if (aux_ready_i)    // no new read before acceptance
                    begin
                        state_q <= last_round ? STR_IDLE : STR_READ;
                        round_q <= round_q + 1'b1;
                    end
                end
                default: state_q <= STR_IDLE;
            endcase
        end
    end

    // beat held stable until accepted
    always_ff @(posedge clk)
    begin
        if (state_q == STR_CAPT)
        begin
            aux_o.data <= rdata_i;
            aux_o.last <= last_round;
        end
    end

endmodule

// File: tape_engine_top.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module tape_engine_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_valid_i,
    input  logic [`SEED_W-1:0]      seed_i,
    input  logic                    aux_ready_i,
    output logic                    start_ready_o,
    output logic                    aux_valid_o,
    output tapes_pkg::aux_beat_t    aux_o
);

    tapes_pkg::mem_req_t     fill_req;
    tapes_pkg::mem_req_t     acc_req;
    tapes_pkg::mem_req_t     strm_req;
    tapes_pkg::mem_req_t     ram_req;
    logic                    fill_valid;
    logic                    acc_valid;
    logic                    strm_valid;
    logic                    fill_grant;
    logic                    acc_grant;
    logic                    strm_grant;
    logic                    ram_valid;
    logic [`TAPE_WORD_W-1:0] ram_rdata;     // shared by all readers
    logic                    fill_done;
    logic                    acc_done;
    logic                    stream_done;

    tape_filler i_tape_filler (
        .clk            (clk),
        .rst            (rst),
        .start_valid_i  (start_valid_i),
        .seed_i         (seed_i),
        .grant_i        (fill_grant),
        .stream_done_i  (stream_done),
        .start_ready_o  (start_ready_o),
        .req_o          (fill_req),
        .req_valid_o    (fill_valid),
        .fill_done_o    (fill_done)
    );

    aux_accumulator i_aux_accumulator (
        .clk            (clk),
        .rst            (rst),
        .start_i        (fill_done),
        .grant_i        (acc_grant),
        .rdata_i        (ram_rdata),
        .req_o          (acc_req),
        .req_valid_o    (acc_valid),
        .done_o         (acc_done)
    );

    aux_streamer i_aux_streamer (
        .clk            (clk),
        .rst            (rst),
        .start_i        (acc_done),
        .grant_i        (strm_grant),
        .rdata_i        (ram_rdata),
        .aux_ready_i    (aux_ready_i),
        .req_o          (strm_req),
        .req_valid_o    (strm_valid),
        .aux_valid_o    (aux_valid_o),
        .aux_o          (aux_o),
        .done_o         (stream_done)
    );

    mem_arbiter i_mem_arbiter (
        .fill_req_i     (fill_req),
        .acc_req_i      (acc_req),
        .strm_req_i     (strm_req),
        .fill_valid_i   (fill_valid),
        .acc_valid_i    (acc_valid),
        .strm_valid_i   (strm_valid),
        .fill_grant_o   (fill_grant),
        .acc_grant_o    (acc_grant),
        .strm_grant_o   (strm_grant),
        .ram_req_o      (ram_req),
        .ram_valid_o    (ram_valid)
    );

    shared_ram i_shared_ram (
        .clk            (clk),
        .req_i          (ram_req),
        .req_valid_i    (ram_valid),
        .rdata_o        (ram_rdata)
    );

endmodule

// File: tape_engine_asserts.sv
`timescale 1ns/100ps

module tape_engine_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 start_ready_i,
    input logic                 aux_valid_i,
    input logic                 aux_ready_i,
    input tapes_pkg::aux_beat_t aux_i,
    input logic                 fill_valid_i,
    input logic                 acc_valid_i,
    input logic                 strm_valid_i
);

    // stalled beat must not change
    assert property (@(posedge clk) disable iff (!rst)
        aux_valid_i && !aux_ready_i |=> $stable(aux_i))
        else $error("aux beat changed while stalled");

    // phases never overlap, so one peer at most asks for the ram port
    assert property (@(posedge clk) disable iff (!rst)
        $onehot0({fill_valid_i, acc_valid_i, strm_valid_i}))
        else $error("more than one ram requester in a cycle");

    // idle engine has nothing to offer
    assert property (@(posedge clk) disable iff (!rst)
        !(aux_valid_i && start_ready_i))
        else $error("aux_valid high while engine idle");

endmodule

bind tape_engine_top tape_engine_asserts i_tape_engine_asserts (
    .clk            (clk),
    .rst            (rst),
    .start_ready_i  (start_ready_o),
    .aux_valid_i    (aux_valid_o),
    .aux_ready_i    (aux_ready_i),
    .aux_i          (aux_o),
    .fill_valid_i   (fill_valid),
    .acc_valid_i    (acc_valid),
    .strm_valid_i   (strm_valid)
);

// File: tb_tape_engine.sv
`timescale 1ns/100ps
`include "tapes_consts.svh"

module tb_tape_engine;

    localparam int NUM_TESTS     = 4;
    localparam int TIMEOUT_LIMIT = 2000 * NUM_TESTS + 100;

    logic                   clk;
    logic                   rst;
    logic                   start_valid_i;
    logic [`SEED_W-1:0]     seed_i;
    logic                   aux_ready_i;
    logic                   start_ready_o;
    logic                   aux_valid_o;
    tapes_pkg::aux_beat_t   aux_o;

    // stimulus table, one row per test
    string                  test_name [NUM_TESTS];
    logic [`SEED_W-1:0]     test_seed [NUM_TESTS];
    bit                     test_busy [NUM_TESTS];     // offer a start while busy

    logic [`TAPE_WORD_W-1:0] expected_aux [`NUM_ROUNDS];
    int                      error_count;
    int                      check_count;
    int                      cycle_count;

    tape_engine_top i_tape_engine_top (
        .clk            (clk),
        .rst            (rst),
        .start_valid_i  (start_valid_i),
        .seed_i         (seed_i),
        .aux_ready_i    (aux_ready_i),
        .start_ready_o  (start_ready_o),
        .aux_valid_o    (aux_valid_o),
        .aux_o          (aux_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [`TAPE_WORD_W:0] exp,
                               input logic [`TAPE_WORD_W:0] act);
        check_count++;
        if (exp !== act)
        begin
            error_count++;
            $display("FAILED %s expected %h actual %h", what, exp, act);
        end
    endtask

    function automatic logic [`SEED_W-1:0] xorshift32(input logic [`SEED_W-1:0] x);
        logic [`SEED_W-1:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // expand the seed into the tape, then fold the strided words per round
    task automatic compute_expected(input logic [`SEED_W-1:0] seed);
        logic [`TAPE_WORD_W-1:0] tape [`TAPE_DEPTH];
        logic [`LANE_W-1:0]      state;
        logic [`LANE_W-1:0]      lo;
        state = seed;
        for (int a = 0; a < `TAPE_DEPTH; a++)
        begin
            lo      = xorshift32(state);
            state   = xorshift32(lo);
            tape[a] = {state, lo};      // second step is the high lane
        end
        for (int r = 0; r < `NUM_ROUNDS; r++)
        begin
            expected_aux[r] = '0;
            for (int k = 0; k < `NUM_SBOX; k++)
            begin
                for (int j = 0; j < `READS_PER_INDEX; j++)
                begin
                    expected_aux[r] ^= tape[r * `NUM_SBOX + k + `READ_STRIDE * j];
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        int                       beats;
        bit                       was_stalled;
        logic [`TAPE_WORD_W:0]    held;
        compute_expected(test_seed[t]);
        @(negedge clk);
        start_valid_i = 1'b1;
        seed_i        = test_seed[t];
        while (!start_ready_o)
        begin
            @(negedge clk);
        end
        @(negedge clk);                 // start taken on the edge just passed
        start_valid_i = test_busy[t];
        seed_i        = ~test_seed[t];  // must be ignored while busy
        beats         = 0;
        was_stalled   = 1'b0;
        while (beats < `NUM_ROUNDS)
        begin
            check_value($sformatf("%s start_ready while busy", test_name[t]), 0, start_ready_o);
            if (was_stalled)
            begin
                check_value($sformatf("%s held beat", test_name[t]), held, aux_o);
                check_value($sformatf("%s held valid", test_name[t]), 1, aux_valid_o);
            end
            aux_ready_i = ($urandom_range(0, 3) != 0);
            was_stalled = 1'b0;
            if (aux_valid_o && aux_ready_i)
            begin
                check_value($sformatf("%s beat %0d data", test_name[t], beats),
                            {1'b0, expected_aux[beats]}, {1'b0, aux_o.data});
                check_value($sformatf("%s beat %0d last", test_name[t], beats),
                            (beats == `NUM_ROUNDS - 1), aux_o.last);
                beats++;
            end
            else if (aux_valid_o)
            begin
                was_stalled = 1'b1;
                held        = aux_o;
            end
            @(negedge clk);
        end
        start_valid_i = 1'b0;
        aux_ready_i   = 1'b0;
        check_value($sformatf("%s start_ready after last", test_name[t]), 1, start_ready_o);
        check_value($sformatf("%s aux_valid after last", test_name[t]), 0, aux_valid_o);
    endtask

    // watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        rst           = 1'b0;
        start_valid_i = 1'b0;
        seed_i        = '0;
        aux_ready_i   = 1'b0;
        error_count   = 0;
        check_count   = 0;
        void'($urandom(32'h70e2_9086));
        test_name[0] = "seed_one";
        test_seed[0] = 32'h0000_0001;
        test_busy[0] = 1'b0;
        test_name[1] = "busy_offer";
        test_seed[1] = 32'h2545_f491;
        test_busy[1] = 1'b1;
        test_name[2] = "all_ones";
        test_seed[2] = 32'hffff_ffff;
        test_busy[2] = 1'b1;
        test_name[3] = "random_seed";
        test_seed[3] = $urandom | 32'h1;    // keep it nonzero
        test_busy[3] = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("reset start_ready", 1, start_ready_o);
        check_value("reset aux_valid", 0, aux_valid_o);
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
tapes_pkg.sv
shared_ram.sv
mem_arbiter.sv
tape_filler.sv
aux_accumulator.sv
aux_streamer.sv
tape_engine_top.sv
tape_engine_asserts.sv
tb_tape_engine.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tape engine testbench, fail if the log reports a failure
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_tape_engine \
    -o sim_tape_engine \
    && ./obj_dir/sim_tape_engine 2>&1 | tee sim.log \
    && ! grep -q "STATUS: FAIL" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
